//--- src/pd_mem_pkg.sv
`default_nettype none

package pd_mem_pkg;

	// Default sizes
	localparam int NUM_PU_DEF = 4;
	localparam int WORD_W_DEF = 32;
	localparam int TID_W_DEF = 2;
	localparam int IDX_W_DEF = 4;

	// Region field at the top of the request address
	localparam int REGION_W = 4;
	localparam logic [REGION_W-1:0] REGION_TOPIC = 4'h5;

	// AMO function codes
	localparam int F5_W = 5;
	localparam logic [F5_W-1:0] F5_SWAP = 5'b00001;

	// Operation group in funct5[4:2]
	localparam int OP_W = 3;
	localparam logic [OP_W-1:0] OP_ADD = 3'b000;
	localparam logic [OP_W-1:0] OP_XOR = 3'b001;
	localparam logic [OP_W-1:0] OP_OR = 3'b010;
	localparam logic [OP_W-1:0] OP_AND = 3'b011;
	localparam logic [OP_W-1:0] OP_MIN = 3'b100;
	localparam logic [OP_W-1:0] OP_MAX = 3'b101;
	localparam logic [OP_W-1:0] OP_MINU = 3'b110;
	localparam logic [OP_W-1:0] OP_MAXU = 3'b111;

endpackage

`default_nettype wire

//--- src/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
	parameter int NUM_PU = pd_mem_pkg::NUM_PU_DEF,
	parameter int SEL_W = (NUM_PU > 1) ? $clog2(NUM_PU) : 1
) (
	input wire clk,
	input wire rst_n,
	input wire en,
	input wire [NUM_PU-1:0] req,
	output logic [SEL_W-1:0] sel,
	output logic gnt
);

	// Index of the last winner; search starts just after it
	logic [SEL_W-1:0] last;
	logic found;

	always_comb begin : pick
		int unsigned idx;
		found = 1'b0;
		sel = last;
		for (int k = 1; k <= NUM_PU; k++) begin
			idx = (int'(last) + k) % NUM_PU;
			if (!found && req[idx]) begin
				found = 1'b1;
				sel = SEL_W'(idx);
			end
		end
		gnt = en && found;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last <= '0;
		end else if (gnt) begin
			last <= sel;
		end
	end

endmodule

`default_nettype wire

//--- src/req_slot.sv
`timescale 1ns/1ps
`default_nettype none

module req_slot #(
	parameter int CMD_W = 8
) (
	input wire clk,
	input wire rst_n,
	input wire load,
	input wire [CMD_W-1:0] cmd_in,
	input wire take,
	output logic pending,
	output logic [CMD_W-1:0] cmd
);

	// A new command wins over a grant in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
		end else if (load) begin
			pending <= 1'b1;
		end else if (take) begin
			pending <= 1'b0;
		end
	end

	// Held until the PU issues again, which only happens after its ack
	always_ff @(posedge clk) begin
		if (load) begin
			cmd <= cmd_in;
		end
	end

endmodule

`default_nettype wire

//--- src/amo_alu.sv
`timescale 1ns/1ps
`default_nettype none

module amo_alu #(
	parameter int WORD_W = pd_mem_pkg::WORD_W_DEF
) (
	input wire [pd_mem_pkg::F5_W-1:0] funct5,
	input wire [WORD_W-1:0] operand,
	input wire [WORD_W-1:0] old_word,
	output logic [WORD_W-1:0] new_word
);

	import pd_mem_pkg::*;

	logic lt_s;
	logic lt_u;

	assign lt_s = $signed(operand) < $signed(old_word);
	assign lt_u = operand < old_word;

	always_comb begin
		if (funct5 == F5_SWAP) begin
			new_word = operand;
		end else begin
			case (funct5[4:2])
				OP_ADD: new_word = operand + old_word;
				OP_XOR: new_word = operand ^ old_word;
				OP_OR: new_word = operand | old_word;
				OP_AND: new_word = operand & old_word;
				OP_MIN: new_word = lt_s ? operand : old_word;
				OP_MAX: new_word = lt_s ? old_word : operand;
				OP_MINU: new_word = lt_u ? operand : old_word;
				OP_MAXU: new_word = lt_u ? old_word : operand;
				default: new_word = operand;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/pd_ram.sv
`timescale 1ns/1ps
`default_nettype none

module pd_ram #(
	parameter int WORD_W = pd_mem_pkg::WORD_W_DEF,
	parameter int DEPTH_W = pd_mem_pkg::TID_W_DEF + pd_mem_pkg::IDX_W_DEF
) (
	input wire clk,
	input wire we,
	input wire [DEPTH_W-1:0] waddr,
	input wire [DEPTH_W-1:0] raddr,
	input wire [WORD_W-1:0] wdata,
	output logic [WORD_W-1:0] rdata
);

	logic [WORD_W-1:0] mem [2**DEPTH_W];

	// Read of the same address as a write returns the old word
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

//--- src/topic_pd_mem.sv
`timescale 1ns/1ps
`default_nettype none

module topic_pd_mem #(
	parameter int NUM_PU = pd_mem_pkg::NUM_PU_DEF,
	parameter int WORD_W = pd_mem_pkg::WORD_W_DEF,
	parameter int TID_W = pd_mem_pkg::TID_W_DEF,
	parameter int IDX_W = pd_mem_pkg::IDX_W_DEF
) (
	input wire clk,
	input wire rst_n,
	input wire [NUM_PU-1:0] req,
	input wire [NUM_PU-1:0] wr,
	input wire [NUM_PU-1:0] atomic,
	input wire [NUM_PU*pd_mem_pkg::F5_W-1:0] funct5,
	input wire [NUM_PU*TID_W-1:0] tid,
	input wire [NUM_PU*(pd_mem_pkg::REGION_W+IDX_W)-1:0] addr,
	input wire [NUM_PU*WORD_W-1:0] wdata,
	output logic [NUM_PU-1:0] ack,
	output logic [NUM_PU*WORD_W-1:0] ack_data
);

	import pd_mem_pkg::*;

	localparam int SEL_W = (NUM_PU > 1) ? $clog2(NUM_PU) : 1;
	localparam int ADDR_W = REGION_W + IDX_W;
	localparam int DEPTH_W = TID_W + IDX_W;
	// Slot layout {wr, atomic, funct5, tid, idx, wdata}
	localparam int CMD_W = 2 + F5_W + DEPTH_W + WORD_W;

	logic [NUM_PU-1:0] load;
	logic [NUM_PU-1:0] take;
	logic [NUM_PU-1:0] pending;
	logic [CMD_W-1:0] slot_cmd [NUM_PU];

	logic [NUM_PU-1:0] s_wr;
	logic [NUM_PU-1:0] s_atomic;
	logic [F5_W-1:0] s_f5 [NUM_PU];
	logic [DEPTH_W-1:0] s_addr [NUM_PU];
	logic [WORD_W-1:0] s_wdata [NUM_PU];

	logic [NUM_PU-1:0] rd_req;
	logic [NUM_PU-1:0] wr_req;
	logic [SEL_W-1:0] rd_sel;
	logic [SEL_W-1:0] wr_sel;
	logic rd_gnt;
	logic wr_gnt;
	logic wr_en;

	logic [DEPTH_W-1:0] ram_raddr;
	logic [DEPTH_W-1:0] ram_waddr;
	logic [WORD_W-1:0] ram_wdata;
	logic [WORD_W-1:0] ram_rdata;
	logic ram_we;
	logic atomic_g;

	// Grant stage delayed by one cycle
	logic rd_gnt_d1;
	logic wr_gnt_d1;
	logic [SEL_W-1:0] rd_sel_d1;
	logic [SEL_W-1:0] wr_sel_d1;

	// Atomic pipeline with stage 1 at G+1 and stage 2 at G+2
	logic at_v1;
	logic at_v2;
	logic [DEPTH_W-1:0] at_addr1;
	logic [DEPTH_W-1:0] at_addr2;
	logic [WORD_W-1:0] at_op1;
	logic [WORD_W-1:0] at_op2;
	logic [F5_W-1:0] at_f5_1;
	logic [F5_W-1:0] at_f5_2;
	logic [WORD_W-1:0] old_word;
	logic [WORD_W-1:0] new_word;

	genvar gp;
	generate
		for (gp = 0; gp < NUM_PU; gp++) begin : g_slot
			assign load[gp] = req[gp] &&
				(addr[gp*ADDR_W+IDX_W +: REGION_W] == REGION_TOPIC);
			assign take[gp] = (rd_gnt && (rd_sel == SEL_W'(gp))) ||
				(wr_gnt && (wr_sel == SEL_W'(gp)));

			req_slot #(
				.CMD_W(CMD_W)
			) u_slot (
				.clk(clk),
				.rst_n(rst_n),
				.load(load[gp]),
				.cmd_in({wr[gp], atomic[gp], funct5[gp*F5_W +: F5_W],
					tid[gp*TID_W +: TID_W], addr[gp*ADDR_W +: IDX_W],
					wdata[gp*WORD_W +: WORD_W]}),
				.take(take[gp]),
				.pending(pending[gp]),
				.cmd(slot_cmd[gp])
			);

			assign {s_wr[gp], s_atomic[gp], s_f5[gp], s_addr[gp], s_wdata[gp]} = slot_cmd[gp];
		end
	endgenerate

	assign ram_raddr = s_addr[rd_sel];
	assign atomic_g = rd_gnt && s_atomic[rd_sel];

	// Hold back same-address traffic until the atomic has written back
	always_comb begin
		for (int p = 0; p < NUM_PU; p++) begin
			rd_req[p] = pending[p] && (s_atomic[p] || !s_wr[p]) &&
				!(at_v1 && (s_addr[p] == at_addr1)) &&
				!(at_v2 && (s_addr[p] == at_addr2));
			wr_req[p] = pending[p] && !s_atomic[p] && s_wr[p] &&
				!(atomic_g && (s_addr[p] == ram_raddr)) &&
				!(at_v1 && (s_addr[p] == at_addr1));
		end
	end

	// Write port belongs to the atomic writeback in its cycle
	assign wr_en = !at_v2;

	rr_arbiter #(
		.NUM_PU(NUM_PU),
		.SEL_W(SEL_W)
	) u_rd_arb (
		.clk(clk),
		.rst_n(rst_n),
		.en(1'b1),
		.req(rd_req),
		.sel(rd_sel),
		.gnt(rd_gnt)
	);

	rr_arbiter #(
		.NUM_PU(NUM_PU),
		.SEL_W(SEL_W)
	) u_wr_arb (
		.clk(clk),
		.rst_n(rst_n),
		.en(wr_en),
		.req(wr_req),
		.sel(wr_sel),
		.gnt(wr_gnt)
	);

	amo_alu #(
		.WORD_W(WORD_W)
	) u_alu (
		.funct5(at_f5_2),
		.operand(at_op2),
		.old_word(old_word),
		.new_word(new_word)
	);

	assign ram_we = at_v2 || wr_gnt;
	assign ram_waddr = at_v2 ? at_addr2 : s_addr[wr_sel];
	assign ram_wdata = at_v2 ? new_word : s_wdata[wr_sel];

	pd_ram #(
		.WORD_W(WORD_W),
		.DEPTH_W(DEPTH_W)
	) u_ram (
		.clk(clk),
		.we(ram_we),
		.waddr(ram_waddr),
		.raddr(ram_raddr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_gnt_d1 <= 1'b0;
			wr_gnt_d1 <= 1'b0;
			at_v1 <= 1'b0;
			at_v2 <= 1'b0;
		end else begin
			rd_gnt_d1 <= rd_gnt;
			wr_gnt_d1 <= wr_gnt;
			at_v1 <= atomic_g;
			at_v2 <= at_v1;
		end
	end

	always_ff @(posedge clk) begin
		rd_sel_d1 <= rd_sel;
		wr_sel_d1 <= wr_sel;
		at_addr1 <= ram_raddr;
		at_op1 <= s_wdata[rd_sel];
		at_f5_1 <= s_f5[rd_sel];
		at_addr2 <= at_addr1;
		at_op2 <= at_op1;
		at_f5_2 <= at_f5_1;
		old_word <= ram_rdata;
	end

	// Read data lands at G+1, so both acks register at the end of G+1
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack <= '0;
			ack_data <= '0;
		end else begin
			for (int p = 0; p < NUM_PU; p++) begin
				ack[p] <= (rd_gnt_d1 && (rd_sel_d1 == SEL_W'(p))) ||
					(wr_gnt_d1 && (wr_sel_d1 == SEL_W'(p)));
				ack_data[p*WORD_W +: WORD_W] <=
					(rd_gnt_d1 && (rd_sel_d1 == SEL_W'(p))) ? ram_rdata : '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/tb_topic_pd_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_topic_pd_mem;

	import pd_mem_pkg::*;

	localparam int NUM_PU = NUM_PU_DEF;
	localparam int WORD_W = WORD_W_DEF;
	localparam int TID_W = TID_W_DEF;
	localparam int IDX_W = IDX_W_DEF;
	localparam int ADDR_W = REGION_W + IDX_W;
	localparam int LOC_W = TID_W + IDX_W;
	localparam int DEPTH = 2 ** LOC_W;
	localparam int TIMEOUT = 200;

	logic clk;
	logic rst_n;
	logic [NUM_PU-1:0] req;
	logic [NUM_PU-1:0] wr;
	logic [NUM_PU-1:0] atomic;
	logic [NUM_PU*F5_W-1:0] funct5;
	logic [NUM_PU*TID_W-1:0] tid;
	logic [NUM_PU*ADDR_W-1:0] addr;
	logic [NUM_PU*WORD_W-1:0] wdata;
	logic [NUM_PU-1:0] ack;
	logic [NUM_PU*WORD_W-1:0] ack_data;

	// Command that each PU has in flight
	logic exp_wr [NUM_PU];
	logic exp_atomic [NUM_PU];
	logic [F5_W-1:0] exp_f5 [NUM_PU];
	int exp_loc [NUM_PU];
	logic [WORD_W-1:0] exp_data [NUM_PU];
	int issued [NUM_PU];

	// RAM shadow with the last returned word and ack counts per PU
	logic [WORD_W-1:0] shadow [DEPTH];
	logic [WORD_W-1:0] last_data [NUM_PU];
	int acked [NUM_PU];

	logic [31:0] lfsr_state;

	topic_pd_mem #(
		.NUM_PU(NUM_PU),
		.WORD_W(WORD_W),
		.TID_W(TID_W),
		.IDX_W(IDX_W)
	) u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.wr(wr),
		.atomic(atomic),
		.funct5(funct5),
		.tid(tid),
		.addr(addr),
		.wdata(wdata),
		.ack(ack),
		.ack_data(ack_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Expected new word of an AMO by the RISC-V definitions
	function automatic logic [WORD_W-1:0] amo_ref(input logic [F5_W-1:0] f5,
		input logic [WORD_W-1:0] op, input logic [WORD_W-1:0] old);
		logic signed [WORD_W-1:0] op_s;
		logic signed [WORD_W-1:0] old_s;
		logic [WORD_W-1:0] res;
		op_s = op;
		old_s = old;
		if (f5 == F5_SWAP) begin
			res = op;
		end else begin
			case (f5[4:2])
				OP_ADD: res = old + op;
				OP_XOR: res = old ^ op;
				OP_OR: res = old | op;
				OP_AND: res = old & op;
				OP_MIN: res = (old_s <= op_s) ? old : op;
				OP_MAX: res = (old_s >= op_s) ? old : op;
				OP_MINU: res = (old <= op) ? old : op;
				default: res = (old >= op) ? old : op;
			endcase
		end
		return res;
	endfunction

	function automatic logic [WORD_W-1:0] fill_word(input int loc);
		return WORD_W'(32'h9E37_79B9 * (loc + 1));
	endfunction

	task automatic report_failure(input string msg);
		$display("error: time %0t %s", $time, msg);
		$display("FAIL: see errors above");
		$fatal(1, "test stopped");
	endtask

	task automatic check_value(input string name, input logic [WORD_W-1:0] got,
		input logic [WORD_W-1:0] expv);
		if (got !== expv) begin
			$display("error: time %0t signal %s got %h expected %h", $time, name, got, expv);
			$display("FAIL: see errors above");
			$fatal(1, "value mismatch");
		end
	endtask

	// Puts one command on the PU's ports; the caller times the req pulse
	task automatic set_cmd(input int p, input logic is_wr, input logic is_at,
		input logic [F5_W-1:0] f5, input int loc, input logic [WORD_W-1:0] data,
		input logic [REGION_W-1:0] region);
		wr[p] = is_wr;
		atomic[p] = is_at;
		funct5[p*F5_W +: F5_W] = f5;
		tid[p*TID_W +: TID_W] = TID_W'(loc >> IDX_W);
		addr[p*ADDR_W +: ADDR_W] = {region, IDX_W'(loc)};
		wdata[p*WORD_W +: WORD_W] = data;
		req[p] = 1'b1;
		if (region == REGION_TOPIC) begin
			exp_wr[p] = is_wr && !is_at;
			exp_atomic[p] = is_at;
			exp_f5[p] = f5;
			exp_loc[p] = loc;
			exp_data[p] = data;
			issued[p]++;
		end
	endtask

	task automatic issue_one(input int p, input logic is_wr, input logic is_at,
		input logic [F5_W-1:0] f5, input int loc, input logic [WORD_W-1:0] data,
		input logic [REGION_W-1:0] region);
		@(posedge clk);
		#1;
		set_cmd(p, is_wr, is_at, f5, loc, data, region);
		@(posedge clk);
		#1;
		req = '0;
	endtask

	task automatic wait_ack(input int p);
		int n;
		n = 0;
		while (acked[p] != issued[p] && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (acked[p] != issued[p]) begin
			report_failure($sformatf("no ack from PU %0d within %0d cycles", p, TIMEOUT));
		end
	endtask

	task automatic write_word(input int p, input int loc, input logic [WORD_W-1:0] data);
		issue_one(p, 1'b1, 1'b0, '0, loc, data, REGION_TOPIC);
		wait_ack(p);
	endtask

	task automatic read_word(input int p, input int loc, output logic [WORD_W-1:0] data);
		issue_one(p, 1'b0, 1'b0, '0, loc, '0, REGION_TOPIC);
		wait_ack(p);
		data = last_data[p];
	endtask

	// Acks are modelled in arrival order with reads before writes in one cycle
	initial begin : monitor
		logic [WORD_W-1:0] got;
		logic [WORD_W-1:0] expv;
		for (int p = 0; p < NUM_PU; p++) begin
			acked[p] = 0;
			last_data[p] = '0;
		end
		forever begin
			@(negedge clk);
			for (int p = 0; p < NUM_PU; p++) begin
				got = ack_data[p*WORD_W +: WORD_W];
				if (rst_n && ack[p]) begin
					if (acked[p] >= issued[p]) begin
						report_failure($sformatf("ack on PU %0d with no request in flight", p));
					end else if (!exp_wr[p]) begin
						expv = shadow[exp_loc[p]];
						check_value($sformatf("ack_data[%0d]", p), got, expv);
						if (exp_atomic[p]) begin
							shadow[exp_loc[p]] = amo_ref(exp_f5[p], exp_data[p], expv);
						end
						last_data[p] = got;
						acked[p]++;
					end
				end
			end
			for (int p = 0; p < NUM_PU; p++) begin
				got = ack_data[p*WORD_W +: WORD_W];
				if (rst_n && ack[p] && exp_wr[p] && acked[p] < issued[p]) begin
					check_value($sformatf("ack_data[%0d]", p), got, '0);
					shadow[exp_loc[p]] = exp_data[p];
					last_data[p] = got;
					acked[p]++;
				end
			end
		end
	end

	initial begin : stimulus
		logic [F5_W-1:0] codes [9];
		logic [WORD_W-1:0] data;
		logic [WORD_W-1:0] old;
		logic [WORD_W-1:0] op;
		logic [WORD_W-1:0] got;
		logic [WORD_W-1:0] total;
		logic [WORD_W-1:0] olds [$];
		logic [WORD_W-1:0] per_tid [2**TID_W];
		int p;
		int q;
		int loc;
		int idx;
		int dups;
		lfsr_state = 32'd74893;
		codes = '{5'b00000, 5'b00001, 5'b00100, 5'b01000, 5'b01100,
			5'b10000, 5'b10100, 5'b11000, 5'b11100};
		rst_n = 1'b0;
		req = '0;
		wr = '0;
		atomic = '0;
		funct5 = '0;
		tid = '0;
		addr = '0;
		wdata = '0;
		for (int i = 0; i < NUM_PU; i++) begin
			issued[i] = 0;
			exp_wr[i] = 1'b0;
			exp_atomic[i] = 1'b0;
			exp_f5[i] = '0;
			exp_loc[i] = 0;
			exp_data[i] = '0;
		end
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Idle after reset
		repeat (20) begin
			@(negedge clk);
			check_value("ack", WORD_W'(ack), '0);
		end

		for (int i = 0; i < DEPTH; i++) begin
			write_word(i % NUM_PU, i, fill_word(i));
		end

		// Plain writes and reads from random PUs
		repeat (24) begin
			p = int'(rand_bits(2)) % NUM_PU;
			q = int'(rand_bits(2)) % NUM_PU;
			loc = int'(rand_bits(LOC_W));
			data = rand_bits(WORD_W);
			write_word(p, loc, data);
			read_word(q, loc, got);
			check_value("ack_data", got, data);
		end

		// Every AMO code from one PU
		for (int c = 0; c < 9; c++) begin
			repeat (3) begin
				p = int'(rand_bits(2)) % NUM_PU;
				loc = int'(rand_bits(LOC_W));
				old = rand_bits(WORD_W);
				op = rand_bits(WORD_W);
				write_word(p, loc, old);
				issue_one(p, 1'b0, 1'b1, codes[c], loc, op, REGION_TOPIC);
				wait_ack(p);
				check_value("ack_data", last_data[p], old);
				read_word(p, loc, got);
				check_value("ack_data", got, amo_ref(codes[c], op, old));
			end
		end

		// All PUs add to one word in the same cycle
		loc = int'(rand_bits(LOC_W));
		total = rand_bits(WORD_W);
		write_word(0, loc, total);
		repeat (4) begin
			@(posedge clk);
			#1;
			for (int i = 0; i < NUM_PU; i++) begin
				op = rand_bits(16) | 32'd1;
				total = total + op;
				set_cmd(i, 1'b0, 1'b1, 5'b00000, loc, op, REGION_TOPIC);
			end
			@(posedge clk);
			#1;
			req = '0;
			for (int i = 0; i < NUM_PU; i++) begin
				wait_ack(i);
				olds.push_back(last_data[i]);
			end
		end
		dups = 0;
		for (int i = 0; i < olds.size(); i++) begin
			for (int j = i + 1; j < olds.size(); j++) begin
				if (olds[i] == olds[j]) begin
					dups++;
				end
			end
		end
		check_value("duplicate_old_values", WORD_W'(dups), '0);
		read_word(1, loc, got);
		check_value("ack_data", got, total);

		// Same index in every thread
		idx = int'(rand_bits(IDX_W));
		for (int t = 0; t < 2**TID_W; t++) begin
			per_tid[t] = rand_bits(WORD_W);
			write_word(t % NUM_PU, (t << IDX_W) | idx, per_tid[t]);
		end
		write_word(2, idx, ~per_tid[0]);
		for (int t = 1; t < 2**TID_W; t++) begin
			read_word(3, (t << IDX_W) | idx, got);
			check_value("ack_data", got, per_tid[t]);
		end

		// Foreign region is dropped
		loc = int'(rand_bits(LOC_W));
		read_word(0, loc, old);
		issue_one(1, 1'b1, 1'b0, '0, loc, ~old, REGION_TOPIC ^ 4'h3);
		issue_one(2, 1'b0, 1'b1, 5'b00001, loc, ~old, REGION_TOPIC ^ 4'h8);
		repeat (TIMEOUT) @(posedge clk);
		read_word(3, loc, got);
		check_value("ack_data", got, old);

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
src/pd_mem_pkg.sv
src/rr_arbiter.sv
src/req_slot.sv
src/amo_alu.sv
src/pd_ram.sv
src/topic_pd_mem.sv
bench/tb_topic_pd_mem.sv

//--- Makefile
SIM      = verilator
TOP      = tb_topic_pd_mem
FILELIST = verilog.f
BUILD    = obj_dir
FLAGS    = --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD)
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
